// ==== hw/zx_bus_pkg.sv ====
package zx_bus_pkg;

	////////////////////////////////////////////////////////////
	// z80 bus widths
	////////////////////////////////////////////////////////////

	parameter int ZA_W = 16;
	parameter int ZD_W = 8;

	////////////////////////////////////////////////////////////
	// port addresses
	////////////////////////////////////////////////////////////

	// fully decoded ports
	parameter logic [ZA_W-1:0] PORT_7FFD = 16'h7FFD;
	parameter logic [ZA_W-1:0] PORT_EFF7 = 16'hEFF7;

	// low byte only; border port looks at a[0] alone
	parameter logic [7:0] PORT_FE_LO = 8'hFE;

	// atm config and page ports
	parameter logic [7:0] PORT_77_LO = 8'h77;
	parameter logic [7:0] PORT_F7_LO = 8'hF7;

	// m1 fetch from 3Dxx enters trdos
	parameter logic [7:0] DOS_TRAP_HI = 8'h3D;

endpackage

// ==== hw/zx_mem_pkg.sv ====
package zx_mem_pkg;

	////////////////////////////////////////////////////////////
	// memory map
	////////////////////////////////////////////////////////////

	parameter int WIN_NUM = 4;
	parameter int PAGE_W  = 7;
	parameter int ROMPG_W = 5;

	// page number plus 16k offset
	parameter int MA_W = 21;

	// pentagon fixed windows
	parameter logic [PAGE_W-1:0] PENT_WIN1_PAGE = 7'd5;
	parameter logic [PAGE_W-1:0] PENT_WIN2_PAGE = 7'd2;

	////////////////////////////////////////////////////////////
	// page word
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic              is_ram;
		logic [PAGE_W-1:0] ram_page;
	} ram_view_t;

	typedef struct packed {
		logic               is_ram;
		logic [1:0]         spare;
		logic [ROMPG_W-1:0] rom_page;
	} rom_view_t;

	// same byte, is_ram picks the view
	typedef union packed {
		ram_view_t ram;
		rom_view_t rom;
	} page_word_t;

endpackage

// ==== hw/zx_ports.sv ====
`timescale 1ns/1ns

module zx_ports (
	input  logic                        fclk,
	input  logic                        rst_n,
	input  logic [zx_bus_pkg::ZA_W-1:0] a,
	input  logic [zx_bus_pkg::ZD_W-1:0] d,
	input  logic                        iorq_n,
	input  logic                        wr_n,
	output logic [7:0]                  p7ffd,
	output logic [2:0]                  border,
	output logic                        turbo,
	output logic                        romrw_en,
	output logic                        pager_off,
	output logic                        cpm_n,
	output logic                        atm_wr
);
	import zx_bus_pkg::*;

	logic io_wr;
	logic io_wr_q;
	logic wr_start;
	logic hit_7ffd;
	logic hit_eff7;
	logic hit_fe;
	logic hit_77;
	logic hit_f7;

	// first sample of an io write
	assign io_wr    = ~iorq_n & ~wr_n;
	assign wr_start = io_wr & ~io_wr_q;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			io_wr_q <= 1'b0;
		else
			io_wr_q <= io_wr;
	end

	////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////

	assign hit_7ffd = (a == PORT_7FFD);
	assign hit_eff7 = (a == PORT_EFF7);
	assign hit_fe   = (a[0] == PORT_FE_LO[0]);
	assign hit_77   = (a[7:0] == PORT_77_LO);
	// EFF7 shares the low byte, it wins over the window 3 pager
	assign hit_f7   = (a[7:0] == PORT_F7_LO) && !hit_eff7;

	////////////////////////////////////////////////////////////
	// config registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			p7ffd     <= 8'h00;
			border    <= 3'd0;
			turbo     <= 1'b0;
			romrw_en  <= 1'b0;
			pager_off <= 1'b1;
			cpm_n     <= 1'b1;
			atm_wr    <= 1'b0;
		end
		else
		begin
			atm_wr <= wr_start && hit_f7;

			if (wr_start && hit_7ffd)
				p7ffd <= d;

			if (wr_start && hit_eff7)
			begin
				turbo    <= d[4];
				romrw_en <= d[3];
			end

			if (wr_start && hit_fe)
				border <= d[2:0];

			// bit 0 enables the atm pager
			if (wr_start && hit_77)
			begin
				pager_off <= ~d[0];
				cpm_n     <= d[1];
			end
		end
	end

	assert property (@(posedge fclk) disable iff (!rst_n) atm_wr |=> !atm_wr)
		else $error("atm_wr high on two consecutive cycles");

endmodule

// ==== hw/atm_pager.sv ====
`timescale 1ns/1ns

module atm_pager #(
	parameter int WIN = 0
)(
	input  logic                        fclk,
	input  logic                        rst_n,
	input  logic [zx_bus_pkg::ZA_W-1:0] a,
	input  logic [zx_bus_pkg::ZD_W-1:0] d,
	input  logic                        atm_wr,
	input  logic                        m1_n,
	input  logic                        mreq_n,
	input  logic [7:0]                  p7ffd,
	input  logic                        pager_off,
	input  logic                        dos,
	output zx_mem_pkg::page_word_t      page,
	output logic                        dos_turn_on,
	output logic                        dos_turn_off
);
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	localparam logic [1:0] WIN_SEL = 2'(WIN);

	// window 0 starts on rom page 0, the rest on ram page WIN
	localparam page_word_t RESET_WORD = (WIN == 0) ? page_word_t'(8'h00) :
		page_word_t'({1'b1, PAGE_W'(WIN)});

	page_word_t slot [2];
	page_word_t pent_word;
	logic       sel;
	logic       m1_fetch;

	assign sel = p7ffd[4];

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			slot[0] <= RESET_WORD;
			slot[1] <= RESET_WORD;
		end
		else if (atm_wr && a[15:14] == WIN_SEL)
			slot[sel] <= page_word_t'(d);
	end

	// pentagon 128 map
	always_comb
	begin
		pent_word = '0;
		case (WIN_SEL)
			2'd0:
			begin
				pent_word.rom.rom_page = {3'b000, ~dos, sel};
			end
			2'd1:
			begin
				pent_word.ram.is_ram   = 1'b1;
				pent_word.ram.ram_page = PENT_WIN1_PAGE;
			end
			2'd2:
			begin
				pent_word.ram.is_ram   = 1'b1;
				pent_word.ram.ram_page = PENT_WIN2_PAGE;
			end
			default:
			begin
				pent_word.ram.is_ram   = 1'b1;
				pent_word.ram.ram_page = {1'b0, p7ffd[7:5], p7ffd[2:0]};
			end
		endcase
	end

	assign page = pager_off ? pent_word : slot[sel];

	// dos traps
	assign m1_fetch = ~m1_n & ~mreq_n;

	assign dos_turn_on = (WIN == 0) && m1_fetch && (a[15:8] == DOS_TRAP_HI) &&
		!page.rom.is_ram && page.rom.rom_page[0];

	// leaving rom for ram drops dos
	assign dos_turn_off = m1_fetch && (a[15:14] == WIN_SEL) && page.ram.is_ram;

endmodule

// ==== hw/zdos.sv ====
`timescale 1ns/1ns

module zdos (
	input  logic                           fclk,
	input  logic                           rst_n,
	input  logic [zx_mem_pkg::WIN_NUM-1:0] dos_turn_on,
	input  logic [zx_mem_pkg::WIN_NUM-1:0] dos_turn_off,
	input  logic                           cpm_n,
	output logic                           dos
);

	logic any_on;
	logic any_off;

	assign any_on  = |dos_turn_on;
	assign any_off = |dos_turn_off;

	// cpm mode pins dos on
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			dos <= 1'b0;
		else if (!cpm_n)
			dos <= 1'b1;
		else if (any_on)
			dos <= 1'b1;
		else if (any_off)
			dos <= 1'b0;
	end

	assert property (@(posedge fclk) disable iff (!rst_n) !cpm_n |=> dos)
		else $error("dos not forced on by cpm_n");

endmodule

// ==== hw/zmem.sv ====
`timescale 1ns/1ns

module zmem (
	input  logic                              fclk,
	input  logic                              rst_n,
	input  logic [zx_bus_pkg::ZA_W-1:0]       a,
	input  logic                              mreq_n,
	input  logic                              rd_n,
	input  logic                              wr_n,
	input  logic                              rfsh_n,
	input  zx_mem_pkg::page_word_t            pages [zx_mem_pkg::WIN_NUM],
	input  logic                              romrw_en,
	output logic [zx_mem_pkg::ROMPG_W-1:0]    rompg,
	output logic                              csrom,
	output logic                              romoe_n,
	output logic                              romwe_n,
	output logic                              ram_cs,
	output logic [zx_mem_pkg::MA_W-1:0]       ram_addr
);
	import zx_mem_pkg::*;

	page_word_t cur;
	logic       access;
	logic       rom_acc;
	logic       ram_acc;

	// window from the top two address bits
	assign cur = pages[a[15:14]];

	// refresh cycles never select memory
	assign access  = ~mreq_n & rfsh_n;
	assign rom_acc = access & ~cur.rom.is_ram;
	assign ram_acc = access & cur.ram.is_ram;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			csrom   <= 1'b0;
			romoe_n <= 1'b1;
			romwe_n <= 1'b1;
			ram_cs  <= 1'b0;
		end
		else
		begin
			csrom   <= rom_acc;
			romoe_n <= ~(rom_acc & ~rd_n);
			romwe_n <= ~(rom_acc & ~wr_n & romrw_en);
			ram_cs  <= ram_acc;
		end
	end

	// rom page pins hold between rom accesses
	always_ff @(posedge fclk)
	begin
		if (rom_acc)
			rompg <= cur.rom.rom_page;
		ram_addr <= {cur.ram.ram_page, a[MA_W-PAGE_W-1:0]};
	end

	assert property (@(posedge fclk) disable iff (!rst_n) !(csrom && ram_cs))
		else $error("rom and ram selected together");

endmodule

// ==== hw/atm_mapper.sv ====
`timescale 1ns/1ns

module atm_mapper (
	input  logic                           fclk,
	input  logic                           rst_n,
	input  logic [zx_bus_pkg::ZA_W-1:0]    a,
	input  logic [zx_bus_pkg::ZD_W-1:0]    d,
	input  logic                           iorq_n,
	input  logic                           mreq_n,
	input  logic                           rd_n,
	input  logic                           wr_n,
	input  logic                           m1_n,
	input  logic                           rfsh_n,
	output logic [zx_mem_pkg::ROMPG_W-1:0] rompg,
	output logic                           csrom,
	output logic                           romoe_n,
	output logic                           romwe_n,
	output logic                           ram_cs,
	output logic [zx_mem_pkg::MA_W-1:0]    ram_addr,
	output logic [2:0]                     border,
	output logic                           turbo
);
	import zx_mem_pkg::*;

	logic [7:0]         p7ffd;
	logic               romrw_en;
	logic               pager_off;
	logic               cpm_n;
	logic               atm_wr;
	logic               dos;
	logic [WIN_NUM-1:0] dos_turn_on;
	logic [WIN_NUM-1:0] dos_turn_off;
	page_word_t         page [WIN_NUM];

	////////////////////////////////////////////////////////////
	// port registers
	////////////////////////////////////////////////////////////

	zx_ports u_ports (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.a         (a),
		.d         (d),
		.iorq_n    (iorq_n),
		.wr_n      (wr_n),
		.p7ffd     (p7ffd),
		.border    (border),
		.turbo     (turbo),
		.romrw_en  (romrw_en),
		.pager_off (pager_off),
		.cpm_n     (cpm_n),
		.atm_wr    (atm_wr)
	);

	////////////////////////////////////////////////////////////
	// window pagers
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < WIN_NUM; i++)
	begin : g_pager
		atm_pager #(
			.WIN (i)
		) u_pager (
			.fclk         (fclk),
			.rst_n        (rst_n),
			.a            (a),
			.d            (d),
			.atm_wr       (atm_wr),
			.m1_n         (m1_n),
			.mreq_n       (mreq_n),
			.p7ffd        (p7ffd),
			.pager_off    (pager_off),
			.dos          (dos),
			.page         (page[i]),
			.dos_turn_on  (dos_turn_on[i]),
			.dos_turn_off (dos_turn_off[i])
		);
	end

	zdos u_zdos (
		.fclk         (fclk),
		.rst_n        (rst_n),
		.dos_turn_on  (dos_turn_on),
		.dos_turn_off (dos_turn_off),
		.cpm_n        (cpm_n),
		.dos          (dos)
	);

	////////////////////////////////////////////////////////////
	// memory controller
	////////////////////////////////////////////////////////////

	zmem u_zmem (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.a        (a),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.rfsh_n   (rfsh_n),
		.pages    (page),
		.romrw_en (romrw_en),
		.rompg    (rompg),
		.csrom    (csrom),
		.romoe_n  (romoe_n),
		.romwe_n  (romwe_n),
		.ram_cs   (ram_cs),
		.ram_addr (ram_addr)
	);

endmodule

// ==== testbench/tb_atm_mapper.sv ====
`timescale 1ns/1ns

module tb_atm_mapper;
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	localparam int          CLK_HALF     = 5;
	localparam int unsigned SEED         = 32'h6b9b_ea25;
	localparam int          IDLE_TIMEOUT = 8;
	localparam int          WATCHDOG_NS  = 200000;

	logic               fclk;
	logic               rst_n;
	logic [ZA_W-1:0]    a;
	logic [ZD_W-1:0]    d;
	logic               iorq_n;
	logic               mreq_n;
	logic               rd_n;
	logic               wr_n;
	logic               m1_n;
	logic               rfsh_n;
	logic [ROMPG_W-1:0] rompg;
	logic               csrom;
	logic               romoe_n;
	logic               romwe_n;
	logic               ram_cs;
	logic [MA_W-1:0]    ram_addr;
	logic [2:0]         border;
	logic               turbo;

	// reference model state
	logic [7:0]         m_p7ffd;
	logic [2:0]         m_border;
	logic               m_turbo;
	logic               m_romrw_en;
	logic               m_pager_off;
	logic               m_cpm_n;
	logic               m_dos;
	logic [ROMPG_W-1:0] m_rompg;
	page_word_t         m_atm [WIN_NUM][2];

	int          checks;
	int          errors;
	int          test_start_errs;

	atm_mapper u_atm_mapper (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.a        (a),
		.d        (d),
		.iorq_n   (iorq_n),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.rfsh_n   (rfsh_n),
		.rompg    (rompg),
		.csrom    (csrom),
		.romoe_n  (romoe_n),
		.romwe_n  (romwe_n),
		.ram_cs   (ram_cs),
		.ram_addr (ram_addr),
		.border   (border),
		.turbo    (turbo)
	);

	initial
	begin
		fclk = 1'b0;
		forever #CLK_HALF fclk = ~fclk;
	end

	initial
	begin
		#WATCHDOG_NS;
		$display("timeout: the run did not reach its end");
		$display("Result: FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic page_word_t model_page(input logic [1:0] win);
		page_word_t w;
		if (!m_pager_off)
			w = m_atm[win][m_p7ffd[4]];
		else if (win == 2'd0)
			w = page_word_t'({6'b000000, ~m_dos, m_p7ffd[4]});
		else if (win == 2'd1)
			w = page_word_t'(8'h85);
		else if (win == 2'd2)
			w = page_word_t'(8'h82);
		else
			w = page_word_t'({2'b10, m_p7ffd[7:5], m_p7ffd[2:0]});
		return w;
	endfunction

	task automatic model_port_write(input logic [ZA_W-1:0] addr, input logic [ZD_W-1:0] data);
		if (addr == PORT_7FFD)
			m_p7ffd = data;
		if (addr == PORT_EFF7)
		begin
			m_turbo    = data[4];
			m_romrw_en = data[3];
		end
		if (!addr[0])
			m_border = data[2:0];
		if (addr[7:0] == PORT_77_LO)
		begin
			m_pager_off = !data[0];
			m_cpm_n     = data[1];
			if (!data[1])
				m_dos = 1'b1;
		end
		// EFF7 is not a page write
		if (addr[7:0] == PORT_F7_LO && addr != PORT_EFF7)
			m_atm[addr[15:14]][m_p7ffd[4]] = page_word_t'(data);
	endtask

	task automatic model_fetch(input logic [ZA_W-1:0] addr);
		page_word_t w;
		w = model_page(addr[15:14]);
		if (!m_cpm_n)
			m_dos = 1'b1;
		else if (addr[15:8] == DOS_TRAP_HI && !w.rom.is_ram && w.rom.rom_page[0])
			m_dos = 1'b1;
		else if (w.ram.is_ram)
			m_dos = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_rom(
		input logic [ROMPG_W-1:0] exp_rompg,
		input logic               exp_csrom,
		input logic               exp_oe_n,
		input logic               exp_we_n
	);
		checks++;
		if (!$isunknown(exp_rompg) && rompg !== exp_rompg)
		begin
			$display("mismatch at %0t: rompg got %h expected %h", $time, rompg, exp_rompg);
			errors++;
		end
		if (csrom !== exp_csrom || romoe_n !== exp_oe_n || romwe_n !== exp_we_n)
		begin
			$display("mismatch at %0t: csrom/romoe_n/romwe_n got %b%b%b expected %b%b%b",
				$time, csrom, romoe_n, romwe_n, exp_csrom, exp_oe_n, exp_we_n);
			errors++;
		end
	endtask

	task automatic check_ram(input logic exp_cs, input logic [MA_W-1:0] exp_addr);
		checks++;
		if (ram_cs !== exp_cs)
		begin
			$display("mismatch at %0t: ram_cs got %b expected %b", $time, ram_cs, exp_cs);
			errors++;
		end
		else if (exp_cs && ram_addr !== exp_addr)
		begin
			$display("mismatch at %0t: ram_addr got %h expected %h", $time, ram_addr, exp_addr);
			errors++;
		end
	endtask

	task automatic check_cfg(input logic [2:0] exp_border, input logic exp_turbo);
		checks++;
		if (border !== exp_border || turbo !== exp_turbo)
		begin
			$display("mismatch at %0t: border/turbo got %h/%b expected %h/%b",
				$time, border, turbo, exp_border, exp_turbo);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// bus cycles
	////////////////////////////////////////////////////////////

	task automatic wait_falls(input int n);
		for (int i = 0; i < n; i++)
			@(negedge fclk);
	endtask

	task automatic bus_idle();
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		rfsh_n = 1'b1;
	endtask

	// selects must drop once mreq_n is released
	task automatic wait_mem_idle();
		int n;
		n = 0;
		while ((csrom || ram_cs || !romoe_n || !romwe_n) && n < IDLE_TIMEOUT)
		begin
			@(negedge fclk);
			n++;
		end
		if (n >= IDLE_TIMEOUT)
		begin
			$display("error at %0t: memory selects stayed active after the access", $time);
			errors++;
		end
	endtask

	task automatic port_write(input logic [ZA_W-1:0] addr, input logic [ZD_W-1:0] data);
		model_port_write(addr, data);
		a      = addr;
		d      = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		wait_falls(2);
		check_cfg(m_border, m_turbo);
		wait_falls(2);
		bus_idle();
		wait_falls(2);
	endtask

	task automatic mem_access(
		input logic [ZA_W-1:0] addr,
		input logic            is_wr,
		input logic            is_m1,
		input logic            do_check
	);
		page_word_t w;
		w      = model_page(addr[15:14]);
		a      = addr;
		d      = 8'(addr);
		mreq_n = 1'b0;
		rd_n   = is_wr;
		wr_n   = !is_wr;
		m1_n   = !is_m1;
		wait_falls(2);
		if (do_check)
		begin
			if (w.ram.is_ram)
			begin
				check_rom(m_rompg, 1'b0, 1'b1, 1'b1);
				check_ram(1'b1, {w.ram.ram_page, addr[13:0]});
			end
			else
			begin
				check_rom(w.rom.rom_page, 1'b1, is_wr, !(is_wr && m_romrw_en));
				check_ram(1'b0, '0);
			end
		end
		wait_falls(2);
		bus_idle();
		if (is_m1)
			model_fetch(addr);
		w = model_page(addr[15:14]);
		if (!w.rom.is_ram)
			m_rompg = w.rom.rom_page;
		wait_mem_idle();
		wait_falls(1);
	endtask

	task automatic random_read(input logic [1:0] win);
		logic [31:0] r;
		r = $urandom;
		mem_access({win, r[13:0]}, 1'b0, 1'b0, 1'b1);
	endtask

	task automatic report_test(input string name);
		$display("test %s: %s, %0d errors", name,
			(errors == test_start_errs) ? "ok" : "bad", errors - test_start_errs);
		test_start_errs = errors;
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0]     r;
		logic [ZA_W-1:0] addr;

		void'($urandom(SEED));
		checks          = 0;
		errors          = 0;
		test_start_errs = 0;
		a      = '0;
		d      = '0;
		rst_n  = 1'b0;
		bus_idle();

		m_p7ffd     = 8'h00;
		m_border    = 3'd0;
		m_turbo     = 1'b0;
		m_romrw_en  = 1'b0;
		m_pager_off = 1'b1;
		m_cpm_n     = 1'b1;
		m_dos       = 1'b0;
		m_rompg     = 'x;
		for (int i = 0; i < WIN_NUM; i++)
		begin
			m_atm[i][0] = page_word_t'((i == 0) ? 8'h00 : 8'h80 + 8'(i));
			m_atm[i][1] = m_atm[i][0];
		end

		wait_falls(3);
		rst_n = 1'b1;
		wait_falls(2);

		// reset state, window 0 is rom page 2
		check_cfg(3'd0, 1'b0);
		mem_access(16'h0000, 1'b0, 1'b0, 1'b1);
		report_test("reset");

		for (int i = 0; i < 24; i++)
		begin
			r = $urandom;
			port_write(PORT_7FFD, r[7:0]);
			for (int w = 0; w < WIN_NUM; w++)
				random_read(2'(w));
		end
		report_test("pentagon");

		for (int i = 0; i < 40; i++)
		begin
			r = $urandom;
			case (r[31:30])
				2'd0:
					addr = {r[15:8], PORT_FE_LO};
				2'd1:
					addr = PORT_EFF7;
				default:
				begin
					addr = {r[15:8], r[7:0] | 8'h01};
					if (addr[7:0] == PORT_77_LO || addr[7:0] == PORT_F7_LO || addr == PORT_7FFD)
						addr[7:0] = 8'h1F;
				end
			endcase
			port_write(addr, r[23:16]);
		end
		report_test("config ports");

		// pager on, cpm off
		r = $urandom;
		port_write({r[7:0], PORT_77_LO}, 8'h03);
		for (int i = 0; i < 16; i++)
		begin
			r = $urandom;
			port_write(PORT_7FFD, {r[7:5], i[0], r[3:0]});
			port_write({r[9:8], r[29:24], PORT_F7_LO}, r[23:16]);
		end
		for (int i = 0; i < 32; i++)
		begin
			r = $urandom;
			if (r[0])
				port_write(PORT_7FFD, r[15:8]);
			random_read(r[17:16]);
		end
		report_test("atm pages");

		port_write({8'h00, PORT_77_LO}, 8'h02);
		port_write(PORT_7FFD, 8'h10);
		mem_access(16'h0123, 1'b0, 1'b0, 1'b1);
		r = $urandom;
		mem_access({DOS_TRAP_HI, r[7:0]}, 1'b0, 1'b1, 1'b0);
		random_read(2'd0);
		mem_access({2'b10, r[21:8]}, 1'b0, 1'b1, 1'b0);
		random_read(2'd0);
		// cpm mode holds dos on
		port_write({8'h00, PORT_77_LO}, 8'h00);
		mem_access({2'b11, r[29:16]}, 1'b0, 1'b1, 1'b0);
		random_read(2'd0);
		port_write({8'h00, PORT_77_LO}, 8'h02);
		random_read(2'd0);
		report_test("dos");

		port_write(PORT_EFF7, 8'h00);
		for (int i = 0; i < 6; i++)
		begin
			r = $urandom;
			mem_access({2'b00, r[13:0]}, 1'b1, 1'b0, 1'b1);
		end
		port_write(PORT_EFF7, 8'h08);
		for (int i = 0; i < 8; i++)
		begin
			r = $urandom;
			mem_access(r[15:0], 1'b1, 1'b0, 1'b1);
		end
		report_test("rom writes");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== atm_mapper.f ====
hw/zx_bus_pkg.sv
hw/zx_mem_pkg.sv
hw/zx_ports.sv
hw/atm_pager.sv
hw/zdos.sv
hw/zmem.sv
hw/atm_mapper.sv
testbench/tb_atm_mapper.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the atm_mapper testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_atm_mapper \
	-f atm_mapper.f --Mdir obj_dir -o tb_atm_mapper
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_atm_mapper > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
	exit 1
fi
exit 0
